/* src/cache_cfg_pkg.sv */
`default_nettype none

package cache_cfg_pkg;

   ////////////////////////////////
   // Cache geometry
   ////////////////////////////////

   localparam int ADDR_BITS      = 32;
   localparam int WORD_BITS      = 32;
   localparam int WORDS_PER_LINE = 4;
   localparam int LINE_BITS      = WORDS_PER_LINE * WORD_BITS;
   // Byte offset within one line
   localparam int OFFSET_BITS    = $clog2(LINE_BITS / 8);
   localparam int LINE_ADDR_BITS = ADDR_BITS - OFFSET_BITS;

   typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;
   typedef logic [LINE_BITS-1:0]      line_t;

   ////////////////////////////////
   // Memory side, one line per beat
   ////////////////////////////////

   typedef struct packed {
      logic       valid;
      logic       we;
      line_addr_t addr;
      line_t      wdata;
   } mem_req_t;

   typedef struct packed {
      logic  ready;
      logic  rvalid;
      line_t rdata;
   } mem_rsp_t;

endpackage

`default_nettype wire

/* src/axil_pkg.sv */
`default_nettype none

package axil_pkg;

   localparam int AXIL_ADDR_W = 32;
   localparam int AXIL_DATA_W = 32;
   localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

   // Only OKAY is ever returned
   localparam logic [1:0] RESP_OKAY = 2'b00;

   ////////////////////////////////
   // Master to slave
   ////////////////////////////////

   typedef struct packed {
      logic                   aw_valid;
      logic [AXIL_ADDR_W-1:0] aw_addr;
      logic                   w_valid;
      logic [AXIL_DATA_W-1:0] w_data;
      logic [AXIL_STRB_W-1:0] w_strb;
      logic                   b_ready;
      logic                   ar_valid;
      logic [AXIL_ADDR_W-1:0] ar_addr;
      logic                   r_ready;
   } axil_req_t;

   ////////////////////////////////
   // Slave to master
   ////////////////////////////////

   typedef struct packed {
      logic                   aw_ready;
      logic                   w_ready;
      logic                   b_valid;
      logic [1:0]             b_resp;
      logic                   ar_ready;
      logic                   r_valid;
      logic [AXIL_DATA_W-1:0] r_data;
      logic [1:0]             r_resp;
   } axil_rsp_t;

endpackage

`default_nettype wire

/* src/data_cache_word_block.sv */
`default_nettype none

module data_cache_word_block #(
   parameter int INDEX_WIDTH = 2
) (
   input  wire logic                   clk_i,
   input  wire logic [INDEX_WIDTH-1:0] addr_r_i,
   input  wire logic [INDEX_WIDTH-1:0] addr_w_i,
   input  wire logic [31:0]            data_i,
   input  wire logic [3:0]             write_en_i,
   input  wire logic                   fill_en_i,
   input  wire logic [31:0]            fill_data_i,
   output logic      [31:0]            data_o
);

   localparam int DEPTH = 2 ** INDEX_WIDTH;

   logic [31:0] mem_q [DEPTH];

   // Fill replaces the whole word, byte writes otherwise
   always_ff @(posedge clk_i) begin
      if (fill_en_i) begin
         mem_q[addr_w_i] <= fill_data_i;
      end else begin
         for (int b = 0; b < 4; b++) begin
            if (write_en_i[b]) begin
               mem_q[addr_w_i][8*b +: 8] <= data_i[8*b +: 8];
            end
         end
      end
   end

   // Registered read, one cycle
   always_ff @(posedge clk_i) begin
      data_o <= mem_q[addr_r_i];
   end

endmodule

`default_nettype wire

/* src/data_cache_qword_block.sv */
`default_nettype none

module data_cache_qword_block
   import cache_cfg_pkg::*;
#(
   parameter int INDEX_WIDTH = 2
) (
   input  wire logic                      clk_i,
   input  wire logic                      rst_i,
   input  wire logic [INDEX_WIDTH-1:0]    addr_r_i,
   input  wire logic [INDEX_WIDTH+1:0]    addr_w_i,
   input  wire logic [31:0]               data_i,
   input  wire logic [3:0]                write_en_i,
   input  wire logic [LINE_BITS-1:0]      fill_data_i,
   input  wire logic [2**INDEX_WIDTH-1:0] fill_line_i,
   input  wire logic                      cleaned_i,
   output logic      [31:0]               data0_o,
   output logic      [31:0]               data1_o,
   output logic      [31:0]               data2_o,
   output logic      [31:0]               data3_o,
   output logic      [2**INDEX_WIDTH-1:0] dirty_o
);

   localparam int LINES = 2 ** INDEX_WIDTH;

   logic [INDEX_WIDTH-1:0] w_idx;
   logic [1:0]             w_sel;
   logic                   fill_en;
   logic [31:0]            bank_data [WORDS_PER_LINE];

   assign w_idx   = addr_w_i[INDEX_WIDTH+1:2];
   assign w_sel   = addr_w_i[1:0];
   // Fill targets the line named by the write index
   assign fill_en = fill_line_i[w_idx];

   for (genvar i = 0; i < WORDS_PER_LINE; i++) begin : g_bank
      logic [3:0] bank_wen;

      // Byte enables go only to the selected word bank
      assign bank_wen = (w_sel == i) ? write_en_i : 4'b0000;

      data_cache_word_block #(
         .INDEX_WIDTH(INDEX_WIDTH)
      ) i_bank (
         .clk_i      (clk_i),
         .addr_r_i   (addr_r_i),
         .addr_w_i   (w_idx),
         .data_i     (data_i),
         .write_en_i (bank_wen),
         .fill_en_i  (fill_en),
         .fill_data_i(fill_data_i[32*i +: 32]),
         .data_o     (bank_data[i])
      );
   end

   assign data0_o = bank_data[0];
   assign data1_o = bank_data[1];
   assign data2_o = bank_data[2];
   assign data3_o = bank_data[3];

   ////////////////////////////////
   // Dirty bits, one per line
   ////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         dirty_o <= '0;
      end else begin
         for (int l = 0; l < LINES; l++) begin
            if (fill_line_i[l]) begin
               dirty_o[l] <= ~cleaned_i;
            end else if ((|write_en_i) && (w_idx == l)) begin
               dirty_o[l] <= 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* src/data_cache_ctrl.sv */
`default_nettype none

module data_cache_ctrl
   import cache_cfg_pkg::*;
   import axil_pkg::*;
#(
   parameter int INDEX_WIDTH = 2
) (
   input  wire logic                      clk_i,
   input  wire logic                      rst_i,
   input  wire axil_req_t                 axil_req_i,
   output axil_rsp_t                      axil_rsp_o,
   output mem_req_t                       mem_req_o,
   input  wire mem_rsp_t                  mem_rsp_i,
   output logic      [INDEX_WIDTH-1:0]    rd_idx_o,
   output logic      [INDEX_WIDTH+1:0]    wr_addr_o,
   output logic      [31:0]               wr_data_o,
   output logic      [3:0]                wr_en_o,
   output logic      [LINE_BITS-1:0]      fill_data_o,
   output logic      [2**INDEX_WIDTH-1:0] fill_line_o,
   output logic                           cleaned_o,
   input  wire logic [LINE_BITS-1:0]      line_i,
   input  wire logic [2**INDEX_WIDTH-1:0] dirty_i
);

   localparam int LINES     = 2 ** INDEX_WIDTH;
   localparam int TAG_WIDTH = ADDR_BITS - OFFSET_BITS - INDEX_WIDTH;
   localparam int WSEL_BITS = $clog2(WORDS_PER_LINE);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_LOOKUP,
      ST_WRITEBACK,
      ST_FILL_REQ,
      ST_FILL_WAIT,
      ST_RESPOND
   } state_e;

   state_e                 state_q;
   // Second lookup cycle, array data is valid
   logic                   lookup_rd_q;
   logic [LINES-1:0]       valid_q;
   logic [TAG_WIDTH-1:0]   tag_q [LINES];

   // Latched request
   logic [ADDR_BITS-1:0]   req_addr_q;
   logic                   req_write_q;
   logic [31:0]            req_wdata_q;
   logic [3:0]             req_strb_q;

   logic                   r_valid_q;
   logic                   b_valid_q;
   logic [31:0]            r_data_q;

   logic [INDEX_WIDTH-1:0] req_idx;
   logic [TAG_WIDTH-1:0]   req_tag;
   logic [WSEL_BITS-1:0]   req_word;
   logic                   hit;
   logic                   compare;
   logic [31:0]            rd_word;
   logic                   ar_fire;
   logic                   aw_fire;
   logic                   fill_done;

   assign req_idx  = req_addr_q[OFFSET_BITS +: INDEX_WIDTH];
   assign req_tag  = req_addr_q[ADDR_BITS-1 -: TAG_WIDTH];
   assign req_word = req_addr_q[OFFSET_BITS-1 -: WSEL_BITS];

   assign hit       = valid_q[req_idx] && (tag_q[req_idx] == req_tag);
   assign compare   = (state_q == ST_LOOKUP) && lookup_rd_q;
   assign rd_word   = line_i[32*req_word +: 32];
   assign fill_done = (state_q == ST_FILL_WAIT) && mem_rsp_i.rvalid;

   // Reads win when both are pending
   assign ar_fire = (state_q == ST_IDLE) && axil_req_i.ar_valid;
   assign aw_fire = (state_q == ST_IDLE) && !axil_req_i.ar_valid
                    && axil_req_i.aw_valid && axil_req_i.w_valid;

   ////////////////////////////////
   // AXI4-Lite response side
   ////////////////////////////////

   always_comb begin
      axil_rsp_o          = '0;
      axil_rsp_o.ar_ready = (state_q == ST_IDLE);
      axil_rsp_o.aw_ready = aw_fire;
      axil_rsp_o.w_ready  = aw_fire;
      axil_rsp_o.r_valid  = r_valid_q;
      axil_rsp_o.r_data   = r_data_q;
      axil_rsp_o.r_resp   = RESP_OKAY;
      axil_rsp_o.b_valid  = b_valid_q;
      axil_rsp_o.b_resp   = RESP_OKAY;
   end

   ////////////////////////////////
   // Memory side requests
   ////////////////////////////////

   always_comb begin
      mem_req_o.valid = (state_q == ST_WRITEBACK) || (state_q == ST_FILL_REQ);
      mem_req_o.we    = (state_q == ST_WRITEBACK);
      // Victim line address comes from the stored tag
      mem_req_o.addr  = (state_q == ST_WRITEBACK) ? {tag_q[req_idx], req_idx}
                                                   : req_addr_q[ADDR_BITS-1:OFFSET_BITS];
      mem_req_o.wdata = line_i;
   end

   // Data array controls
   assign rd_idx_o    = req_idx;
   assign wr_addr_o   = {req_idx, req_word};
   assign wr_data_o   = req_wdata_q;
   assign wr_en_o     = (compare && hit && req_write_q) ? req_strb_q : 4'b0000;
   assign fill_data_o = mem_rsp_i.rdata;
   assign cleaned_o   = (state_q == ST_FILL_WAIT);

   always_comb begin
      fill_line_o = '0;
      if (fill_done) begin
         fill_line_o[req_idx] = 1'b1;
      end
   end

   ////////////////////////////////
   // FSM
   ////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q     <= ST_IDLE;
         lookup_rd_q <= 1'b0;
         valid_q     <= '0;
         r_valid_q   <= 1'b0;
         b_valid_q   <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (ar_fire || aw_fire) begin
                  state_q     <= ST_LOOKUP;
                  lookup_rd_q <= 1'b0;
               end
            end
            ST_LOOKUP: begin
               if (!lookup_rd_q) begin
                  lookup_rd_q <= 1'b1;
               end else if (hit) begin
                  state_q   <= ST_RESPOND;
                  r_valid_q <= !req_write_q;
                  b_valid_q <= req_write_q;
               end else if (valid_q[req_idx] && dirty_i[req_idx]) begin
                  state_q <= ST_WRITEBACK;
               end else begin
                  state_q <= ST_FILL_REQ;
               end
            end
            ST_WRITEBACK: begin
               if (mem_rsp_i.ready) begin
                  state_q <= ST_FILL_REQ;
               end
            end
            ST_FILL_REQ: begin
               if (mem_rsp_i.ready) begin
                  state_q <= ST_FILL_WAIT;
               end
            end
            ST_FILL_WAIT: begin
               // Replay the access once the line is in
               if (mem_rsp_i.rvalid) begin
                  valid_q[req_idx] <= 1'b1;
                  state_q          <= ST_LOOKUP;
                  lookup_rd_q      <= 1'b0;
               end
            end
            ST_RESPOND: begin
               if ((r_valid_q && axil_req_i.r_ready) || (b_valid_q && axil_req_i.b_ready)) begin
                  r_valid_q <= 1'b0;
                  b_valid_q <= 1'b0;
                  state_q   <= ST_IDLE;
               end
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   // Request payload, tags and read data
   always_ff @(posedge clk_i) begin
      if (ar_fire) begin
         req_addr_q  <= axil_req_i.ar_addr;
         req_write_q <= 1'b0;
      end else if (aw_fire) begin
         req_addr_q  <= axil_req_i.aw_addr;
         req_write_q <= 1'b1;
         req_wdata_q <= axil_req_i.w_data;
         req_strb_q  <= axil_req_i.w_strb;
      end
      if (fill_done) begin
         tag_q[req_idx] <= req_tag;
      end
      if (compare && hit && !req_write_q) begin
         r_data_q <= rd_word;
      end
   end

endmodule

`default_nettype wire

/* src/data_cache_top.sv */
`default_nettype none

module data_cache_top
   import cache_cfg_pkg::*;
   import axil_pkg::*;
#(
   parameter int INDEX_WIDTH = 2
) (
   input  wire logic      clk_i,
   input  wire logic      rst_i,
   input  wire axil_req_t axil_req_i,
   output axil_rsp_t      axil_rsp_o,
   output mem_req_t       mem_req_o,
   input  wire mem_rsp_t  mem_rsp_i
);

   localparam int LINES = 2 ** INDEX_WIDTH;

   logic [INDEX_WIDTH-1:0] rd_idx;
   logic [INDEX_WIDTH+1:0] wr_addr;
   logic [31:0]            wr_data;
   logic [3:0]             wr_en;
   logic [LINE_BITS-1:0]   fill_data;
   logic [LINES-1:0]       fill_line;
   logic                   cleaned;
   logic [31:0]            word0;
   logic [31:0]            word1;
   logic [31:0]            word2;
   logic [31:0]            word3;
   logic [LINES-1:0]       dirty;

   data_cache_ctrl #(
      .INDEX_WIDTH(INDEX_WIDTH)
   ) i_ctrl (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .axil_req_i (axil_req_i),
      .axil_rsp_o (axil_rsp_o),
      .mem_req_o  (mem_req_o),
      .mem_rsp_i  (mem_rsp_i),
      .rd_idx_o   (rd_idx),
      .wr_addr_o  (wr_addr),
      .wr_data_o  (wr_data),
      .wr_en_o    (wr_en),
      .fill_data_o(fill_data),
      .fill_line_o(fill_line),
      .cleaned_o  (cleaned),
      // Word 0 sits in the low bits, as on the memory side
      .line_i     ({word3, word2, word1, word0}),
      .dirty_i    (dirty)
   );

   data_cache_qword_block #(
      .INDEX_WIDTH(INDEX_WIDTH)
   ) i_array (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .addr_r_i   (rd_idx),
      .addr_w_i   (wr_addr),
      .data_i     (wr_data),
      .write_en_i (wr_en),
      .fill_data_i(fill_data),
      .fill_line_i(fill_line),
      .cleaned_i  (cleaned),
      .data0_o    (word0),
      .data1_o    (word1),
      .data2_o    (word2),
      .data3_o    (word3),
      .dirty_o    (dirty)
   );

endmodule

`default_nettype wire

/* sim/tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 10
) (
   output logic clk_o,
   output logic rst_o
);
   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // Release reset just after an edge, like the other inputs
   initial begin
      rst_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #2 rst_o = 1'b0;
   end

endmodule

`default_nettype wire

/* sim/tb_data_cache_assert.sv */
`default_nettype none

module tb_data_cache_assert
   import cache_cfg_pkg::*;
   import axil_pkg::*;
(
   input wire logic      clk_i,
   input wire logic      rst_i,
   input wire axil_req_t axil_req_i,
   input wire axil_rsp_t axil_rsp_i,
   input wire mem_req_t  mem_req_i,
   input wire mem_rsp_t  mem_rsp_i
);
   timeunit 1ns;
   timeprecision 1ps;

   int unsigned assert_fails = 0;

   a_r_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      axil_rsp_i.r_valid && !axil_req_i.r_ready
      |=> axil_rsp_i.r_valid && $stable(axil_rsp_i.r_data))
   else begin
      $error("r_valid dropped or r_data changed before the read transfer");
      assert_fails++;
   end

   a_b_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      axil_rsp_i.b_valid && !axil_req_i.b_ready
      |=> axil_rsp_i.b_valid && $stable(axil_rsp_i.b_resp))
   else begin
      $error("b_valid dropped or b_resp changed before the write response transfer");
      assert_fails++;
   end

   // Whole request struct including the payload
   a_mem_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      mem_req_i.valid && !mem_rsp_i.ready
      |=> mem_req_i.valid && $stable(mem_req_i))
   else begin
      $error("memory request dropped or changed before it was accepted");
      assert_fails++;
   end

   // Write accepted in one cycle, only with both channels valid and no read waiting
   a_aw_w: assert property (@(posedge clk_i) disable iff (rst_i)
      (axil_rsp_i.aw_ready || axil_rsp_i.w_ready)
      |-> axil_rsp_i.aw_ready && axil_rsp_i.w_ready
          && axil_req_i.aw_valid && axil_req_i.w_valid && !axil_req_i.ar_valid)
   else begin
      $error("aw_ready and w_ready not raised together on a pending write");
      assert_fails++;
   end

endmodule

bind data_cache_ctrl tb_data_cache_assert i_assert (
   .clk_i     (clk_i),
   .rst_i     (rst_i),
   .axil_req_i(axil_req_i),
   .axil_rsp_i(axil_rsp_o),
   .mem_req_i (mem_req_o),
   .mem_rsp_i (mem_rsp_i)
);

`default_nettype wire

/* sim/tb_data_cache.sv */
`default_nettype none

module tb_data_cache
   import cache_cfg_pkg::*;
   import axil_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int SEED      = 79904;
   localparam int PERIOD    = 40;
   localparam int RST_CYC   = 10;
   localparam int MEM_LINES = 256;
   // Cold read, 8 write/read pairs, 4 write/read pairs, random mix, back-pressure mix
   localparam int N_TRANS   = 1 + 16 + 8 + 300 + 100;

   logic      clk;
   logic      rst;
   axil_req_t axil_req;
   axil_rsp_t axil_rsp;
   mem_req_t  mem_req;
   mem_rsp_t  mem_rsp;

   // Reference words, and the memory model's own line store
   logic [31:0] ref_mem [MEM_LINES*WORDS_PER_LINE];
   line_t       mem_line [MEM_LINES];
   mem_req_t    mem_log [$];
   int unsigned pass_cnt;
   int unsigned fail_cnt;

   tb_clk_gen #(
      .PERIOD_NS   (PERIOD),
      .RESET_CYCLES(RST_CYC)
   ) i_clk_gen (
      .clk_o(clk),
      .rst_o(rst)
   );

   data_cache_top #(
      .INDEX_WIDTH(2)
   ) i_dut (
      .clk_i     (clk),
      .rst_i     (rst),
      .axil_req_i(axil_req),
      .axil_rsp_o(axil_rsp),
      .mem_req_o (mem_req),
      .mem_rsp_i (mem_rsp)
   );

   ////////////////////////////////
   // Helpers
   ////////////////////////////////

   // Start-up memory image with a different word at every word address
   function automatic logic [31:0] init_word(int unsigned waddr);
      return (waddr * 32'h9E37_79B1) ^ {waddr[15:0], ~waddr[15:0]};
   endfunction

   function automatic line_t ref_line(int unsigned laddr);
      line_t l;
      for (int k = 0; k < WORDS_PER_LINE; k++) begin
         l[32*k +: 32] = ref_mem[laddr*WORDS_PER_LINE + k];
      end
      return l;
   endfunction

   function automatic logic [31:0] rand_addr(int unsigned lines);
      return {20'h0, 8'($urandom_range(0, lines - 1)), 2'($urandom_range(0, 3)), 2'b00};
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic check_eq(string what, logic [127:0] got, logic [127:0] exp);
      assert (got === exp) begin
         pass_cnt++;
      end else begin
         $display("[FAIL] %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
         fail_cnt++;
      end
   endtask

   ////////////////////////////////
   // AXI4-Lite master
   ////////////////////////////////

   task automatic axil_read(logic [31:0] addr, bit stall, output logic [31:0] data);
      logic [31:0] first = '0;
      bit          seen  = 1'b0;
      bit          done  = 1'b0;
      axil_req.ar_valid = 1'b1;
      axil_req.ar_addr  = addr;
      do begin
         @(negedge clk);
      end while (!axil_rsp.ar_ready);
      next_cycle();
      axil_req.ar_valid = 1'b0;
      while (!done) begin
         axil_req.r_ready = stall ? ($urandom_range(0, 2) == 0) : 1'b1;
         @(negedge clk);
         if (axil_rsp.r_valid) begin
            if (seen) begin
               check_eq("r_data held while r_valid high", axil_rsp.r_data, first);
            end
            seen  = 1'b1;
            first = axil_rsp.r_data;
            done  = axil_req.r_ready;
            if (done) begin
               check_eq("r_resp", axil_rsp.r_resp, RESP_OKAY);
            end
         end
         next_cycle();
      end
      axil_req.r_ready = 1'b0;
      data = first;
   endtask

   task automatic axil_write(logic [31:0] addr, logic [31:0] data, logic [3:0] strb, bit stall);
      bit done = 1'b0;
      axil_req.aw_valid = 1'b1;
      axil_req.aw_addr  = addr;
      axil_req.w_valid  = 1'b1;
      axil_req.w_data   = data;
      axil_req.w_strb   = strb;
      do begin
         @(negedge clk);
      end while (!(axil_rsp.aw_ready || axil_rsp.w_ready));
      // Address and data are accepted in the same cycle
      check_eq("aw_ready and w_ready together", {axil_rsp.aw_ready, axil_rsp.w_ready}, 2'b11);
      next_cycle();
      axil_req.aw_valid = 1'b0;
      axil_req.w_valid  = 1'b0;
      while (!done) begin
         axil_req.b_ready = stall ? ($urandom_range(0, 2) == 0) : 1'b1;
         @(negedge clk);
         done = axil_rsp.b_valid && axil_req.b_ready;
         if (done) begin
            check_eq("b_resp", axil_rsp.b_resp, RESP_OKAY);
         end
         next_cycle();
      end
      axil_req.b_ready = 1'b0;
      // Strobed bytes replace the old ones
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            ref_mem[addr[11:2]][8*b +: 8] = data[8*b +: 8];
         end
      end
   endtask

   task automatic read_check(logic [31:0] addr, bit stall);
      logic [31:0] data;
      axil_read(addr, stall, data);
      check_eq($sformatf("read data at %h", addr), data, ref_mem[addr[11:2]]);
   endtask

   ////////////////////////////////
   // Tests
   ////////////////////////////////

   task automatic cold_read_miss();
      logic [31:0] addr;
      addr = rand_addr(MEM_LINES);
      mem_log.delete();
      read_check(addr, 1'b0);
      check_eq("line requests for a cold read", mem_log.size(), 1);
      if (mem_log.size() == 1) begin
         check_eq("cold read request we", mem_log[0].we, 1'b0);
         check_eq("cold read line address", mem_log[0].addr, addr[31:OFFSET_BITS]);
      end
   endtask

   task automatic strobed_write_read();
      logic [31:0] addr;
      for (int i = 0; i < 8; i++) begin
         addr = rand_addr(MEM_LINES);
         axil_write(addr, $urandom(), 4'($urandom_range(0, 15)), 1'b0);
         read_check(addr, 1'b0);
      end
   endtask

   task automatic dirty_victim_evict();
      int unsigned line_a;
      int unsigned line_b;
      int unsigned word;
      for (int i = 0; i < 4; i++) begin
         line_a = $urandom_range(0, MEM_LINES - 1);
         // Same index bits with a different tag
         line_b = line_a ^ (4 * $urandom_range(1, MEM_LINES / 4 - 1));
         word   = $urandom_range(0, 3);
         axil_write(line_a * 16 + word * 4, $urandom(), 4'($urandom_range(1, 15)), 1'b0);
         mem_log.delete();
         read_check(line_b * 16 + word * 4, 1'b0);
         check_eq("requests on a dirty miss", mem_log.size(), 2);
         if (mem_log.size() == 2) begin
            check_eq("victim request we", mem_log[0].we, 1'b1);
            check_eq("victim line address", mem_log[0].addr, line_a);
            check_eq("victim line data", mem_log[0].wdata, ref_line(line_a));
            check_eq("fill request we", mem_log[1].we, 1'b0);
            check_eq("fill line address", mem_log[1].addr, line_b);
         end
      end
   endtask

   task automatic random_traffic(int unsigned count, bit stall);
      logic [31:0] addr;
      for (int i = 0; i < count; i++) begin
         addr = rand_addr(64);
         if ($urandom_range(0, 1) == 1) begin
            axil_write(addr, $urandom(), 4'($urandom_range(0, 15)), stall);
         end else begin
            read_check(addr, stall);
         end
      end
   endtask

   ////////////////////////////////
   // Memory model
   ////////////////////////////////

   initial begin : mem_model
      mem_req_t    req;
      int unsigned lat;
      mem_rsp = '0;
      forever begin
         @(negedge clk);
         if (!rst && mem_req.valid) begin
            req = mem_req;
            mem_log.push_back(req);
            repeat ($urandom_range(0, 3)) next_cycle();
            next_cycle();
            mem_rsp.ready = 1'b1;
            next_cycle();
            mem_rsp.ready = 1'b0;
            if (req.we) begin
               mem_line[req.addr[7:0]] = req.wdata;
            end else begin
               lat = $urandom_range(1, 4);
               repeat (lat - 1) next_cycle();
               mem_rsp.rdata  = mem_line[req.addr[7:0]];
               mem_rsp.rvalid = 1'b1;
               next_cycle();
               mem_rsp.rvalid = 1'b0;
            end
         end
      end
   end

   initial begin : watchdog
      #((RST_CYC + 400 * N_TRANS) * PERIOD);
      $display("Timeout: the cache did not finish all transactions in time");
      $display("Test FAILED");
      $finish;
   end

   initial begin : stimulus
      int unsigned fails_before;
      void'($urandom(SEED));
      axil_req = '0;
      pass_cnt = 0;
      fail_cnt = 0;
      for (int w = 0; w < MEM_LINES * WORDS_PER_LINE; w++) begin
         ref_mem[w] = init_word(w);
         mem_line[w / WORDS_PER_LINE][32*(w % WORDS_PER_LINE) +: 32] = init_word(w);
      end
      @(negedge rst);
      next_cycle();

      fails_before = fail_cnt;
      cold_read_miss();
      $display("test 1 cold read: %0d failed checks", fail_cnt - fails_before);
      fails_before = fail_cnt;
      strobed_write_read();
      $display("test 2 strobed write: %0d failed checks", fail_cnt - fails_before);
      fails_before = fail_cnt;
      dirty_victim_evict();
      $display("test 3 dirty victim: %0d failed checks", fail_cnt - fails_before);
      fails_before = fail_cnt;
      random_traffic(300, 1'b0);
      $display("test 4 random mix: %0d failed checks", fail_cnt - fails_before);
      fails_before = fail_cnt;
      random_traffic(100, 1'b1);
      $display("test 5 back-pressure: %0d failed checks", fail_cnt - fails_before);

      fail_cnt += i_dut.i_ctrl.i_assert.assert_fails;
      $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* build.f */
src/cache_cfg_pkg.sv
src/axil_pkg.sv
src/data_cache_word_block.sv
src/data_cache_qword_block.sv
src/data_cache_ctrl.sv
src/data_cache_top.sv
sim/tb_clk_gen.sv
sim/tb_data_cache_assert.sv
sim/tb_data_cache.sv

/* Bender.yml */
package:
  name: data_cache

sources:
  # Packages first, then the design from the leaves up
  - files:
      - src/cache_cfg_pkg.sv
      - src/axil_pkg.sv
      - src/data_cache_word_block.sv
      - src/data_cache_qword_block.sv
      - src/data_cache_ctrl.sv
      - src/data_cache_top.sv

  - target: test
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_data_cache_assert.sv
      - sim/tb_data_cache.sv
